// ==== cpu_pkg.sv ====
// shared word, register, opcode and select types for the pipelined core, used by scoped name
`default_nettype none

package cpu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regbits_t;
   typedef logic [7:0]  mem_addr_t;   // word index into the 256-word memory

   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      ADDIU = 6'b001001,
      ORI   = 6'b001101,
      LUI   = 6'b001111,
      LW    = 6'b100011,
      SW    = 6'b101011,
      HALT  = 6'b111111
   } opcode_t;

   typedef enum logic [5:0] {
      SLL  = 6'b000000,
      ADDU = 6'b100001,
      SUBU = 6'b100011,
      AND  = 6'b100100,
      OR   = 6'b100101,
      SLT  = 6'b101010
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT,
      ALU_SLL
   } alu_op_t;

   // second alu operand source
   typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_UPPER} alu_src_t;

   // forwarding source for an EX operand
   typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_t;

endpackage

`default_nettype wire

// ==== alu.sv ====
// combinational ALU of the EX stage, driven by the ID/EX latch and the forwarding muxes
`timescale 1ns/1ns
`default_nettype none

module alu (
   input  cpu_pkg::word_t   op1,
   input  cpu_pkg::word_t   op2,
   input  logic [4:0]       shamt,
   input  cpu_pkg::alu_op_t alu_op,
   output cpu_pkg::word_t   res
);

   always_comb begin
      case (alu_op)
         cpu_pkg::ALU_ADD: res = op1 + op2;
         cpu_pkg::ALU_SUB: res = op1 - op2;
         cpu_pkg::ALU_AND: res = op1 & op2;
         cpu_pkg::ALU_OR:  res = op1 | op2;
         cpu_pkg::ALU_SLT: res = {31'b0, $signed(op1) < $signed(op2)};  // signed compare
         cpu_pkg::ALU_SLL: res = op2 << shamt;                          // rt shifted, as mips
         default:          res = op1 + op2;
      endcase
   end

endmodule

`default_nettype wire

// ==== register_file.sv ====
// 32x32 register file read in ID and written from WB, with write-to-read bypass
`timescale 1ns/1ns
`default_nettype none

module register_file (
   input  logic               CLK,
   input  logic               rst,
   input  logic               wen,
   input  cpu_pkg::regbits_t  wsel,
   input  cpu_pkg::word_t     wdat,
   input  cpu_pkg::regbits_t  rsel1,
   input  cpu_pkg::regbits_t  rsel2,
   output cpu_pkg::word_t     rdat1,
   output cpu_pkg::word_t     rdat2
);

   cpu_pkg::word_t regs [32];
   logic           wr_live;

   assign wr_live = wen && (wsel != 5'd0);   // $0 is never written

   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[wsel] <= wdat;
      end
   end

   // a same-cycle write shows through, so WB needs no forwarding into ID
   assign rdat1 = (wr_live && wsel == rsel1) ? wdat : regs[rsel1];
   assign rdat2 = (wr_live && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

// ==== control_unit.sv ====
// instruction decoder of the ID stage, turns the IF/ID word into control fields and selects
`timescale 1ns/1ns
`default_nettype none

module control_unit (
   input  cpu_pkg::word_t     instr,
   output cpu_pkg::alu_op_t   alu_op,
   output cpu_pkg::alu_src_t  alu_src,
   output logic               ext_sign,
   output logic               regwr,
   output logic               memtoreg,
   output logic               dmem_ren,
   output logic               dmem_wen,
   output logic               halt,
   output cpu_pkg::regbits_t  rs,
   output cpu_pkg::regbits_t  rt,
   output cpu_pkg::regbits_t  wsel,
   output logic [4:0]         shamt,
   output logic [15:0]        imm16
);

   assign rs    = instr[25:21];
   assign rt    = instr[20:16];
   assign shamt = instr[10:6];
   assign imm16 = instr[15:0];

   always_comb begin
      // anything not listed below falls through as a no-op
      alu_op   = cpu_pkg::ALU_ADD;
      alu_src  = cpu_pkg::SRC_IMM;
      ext_sign = 1'b1;
      regwr    = 1'b0;
      memtoreg = 1'b0;
      dmem_ren = 1'b0;
      dmem_wen = 1'b0;
      halt     = 1'b0;
      wsel     = instr[20:16];   // rt for i-type
      case (instr[31:26])
         cpu_pkg::RTYPE: begin
            alu_src = cpu_pkg::SRC_REG;
            wsel    = instr[15:11];   // rd
            regwr   = 1'b1;
            case (instr[5:0])
               cpu_pkg::ADDU: alu_op = cpu_pkg::ALU_ADD;
               cpu_pkg::SUBU: alu_op = cpu_pkg::ALU_SUB;
               cpu_pkg::AND:  alu_op = cpu_pkg::ALU_AND;
               cpu_pkg::OR:   alu_op = cpu_pkg::ALU_OR;
               cpu_pkg::SLT:  alu_op = cpu_pkg::ALU_SLT;
               cpu_pkg::SLL:  alu_op = cpu_pkg::ALU_SLL;
               default:       regwr  = 1'b0;
            endcase
         end
         cpu_pkg::ADDIU: regwr = 1'b1;
         cpu_pkg::ORI: begin
            alu_op   = cpu_pkg::ALU_OR;
            ext_sign = 1'b0;
            regwr    = 1'b1;
         end
         cpu_pkg::LUI: begin
            alu_op  = cpu_pkg::ALU_OR;   // 0 | upper immediate
            alu_src = cpu_pkg::SRC_UPPER;
            regwr   = 1'b1;
         end
         cpu_pkg::LW: begin
            regwr    = 1'b1;
            memtoreg = 1'b1;
            dmem_ren = 1'b1;
         end
         cpu_pkg::SW:   dmem_wen = 1'b1;
         cpu_pkg::HALT: halt     = 1'b1;
         default:       regwr    = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
// forwarding selects for EX and the load-use stall request for ID, from latch register fields
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
   input  cpu_pkg::regbits_t  id_rs,
   input  cpu_pkg::regbits_t  id_rt,
   input  cpu_pkg::regbits_t  ex_rs,
   input  cpu_pkg::regbits_t  ex_rt,
   input  logic               ex_load,
   input  cpu_pkg::regbits_t  ex_wsel,
   input  cpu_pkg::regbits_t  mem_wsel,
   input  logic               mem_regwr,
   input  cpu_pkg::regbits_t  wb_wsel,
   input  logic               wb_regwr,
   output cpu_pkg::fwd_sel_t  fwd_op1,
   output cpu_pkg::fwd_sel_t  fwd_op2,
   output logic               load_stall
);

   // newest producer wins, so MEM is checked before WB
   function automatic cpu_pkg::fwd_sel_t pick(input cpu_pkg::regbits_t src);
      cpu_pkg::fwd_sel_t sel;
      sel = cpu_pkg::FWD_NONE;
      if (src != 5'd0) begin
         if (mem_regwr && mem_wsel == src) begin
            sel = cpu_pkg::FWD_MEM;
         end else if (wb_regwr && wb_wsel == src) begin
            sel = cpu_pkg::FWD_WB;
         end
      end
      return sel;
   endfunction

   assign fwd_op1 = pick(ex_rs);
   assign fwd_op2 = pick(ex_rt);

   // lw result only exists after MEM, one bubble lets WB forward it
   assign load_stall = ex_load && (ex_wsel != 5'd0) &&
                       (ex_wsel == id_rs || ex_wsel == id_rt);

endmodule

`default_nettype wire

// ==== datapath.sv ====
// five-stage core: PC, pipeline latches, operand muxes and the fetch and data request sides
`timescale 1ns/1ns
`default_nettype none

module datapath #(
   parameter cpu_pkg::word_t PC_INIT = 32'h0
) (
   input  logic               CLK,
   input  logic               rst,
   input  logic               run,
   output logic               i_req,
   output cpu_pkg::mem_addr_t i_addr,
   input  logic               i_ack,
   input  cpu_pkg::word_t     i_rdata,
   output logic               d_req,
   output logic               d_wen,
   output cpu_pkg::mem_addr_t d_addr,
   output cpu_pkg::word_t     d_wdata,
   input  logic               d_ack,
   input  cpu_pkg::word_t     d_rdata,
   output logic               halted
);

   // decode
   cpu_pkg::alu_op_t  cu_alu_op;
   cpu_pkg::alu_src_t cu_alu_src;
   logic              cu_ext_sign, cu_regwr, cu_memtoreg, cu_ren, cu_wen, cu_halt;
   cpu_pkg::regbits_t cu_rs, cu_rt, cu_wsel;
   logic [4:0]        cu_shamt;
   logic [15:0]       cu_imm16;
   cpu_pkg::word_t    rdat1, rdat2, imm_ext;
   cpu_pkg::fwd_sel_t fwd_op1, fwd_op2;
   logic              load_stall;

   // fetch / data handshake state
   cpu_pkg::word_t    pc, fetch_buf, d_load;
   logic              fetch_valid, halt_seen, d_done;
   logic              stop_fetch, mem_op, advance;

   // latches named by stage pair
   cpu_pkg::word_t    fd_instr;
   cpu_pkg::word_t    de_rdat1, de_rdat2, de_imm;
   logic [4:0]        de_shamt;
   cpu_pkg::alu_op_t  de_alu_op;
   cpu_pkg::alu_src_t de_alu_src;
   cpu_pkg::regbits_t de_rs, de_rt, de_wsel;
   logic              de_regwr, de_memtoreg, de_ren, de_wen, de_halt;
   cpu_pkg::word_t    em_alu, em_store;
   cpu_pkg::regbits_t em_wsel;
   logic              em_regwr, em_memtoreg, em_ren, em_wen, em_halt;
   cpu_pkg::word_t    mw_result;
   cpu_pkg::regbits_t mw_wsel;
   logic              mw_regwr;

   cpu_pkg::word_t    op1, op2_reg, op2, alu_res;

   control_unit cu_inst (
      .instr(fd_instr), .alu_op(cu_alu_op), .alu_src(cu_alu_src), .ext_sign(cu_ext_sign),
      .regwr(cu_regwr), .memtoreg(cu_memtoreg), .dmem_ren(cu_ren), .dmem_wen(cu_wen),
      .halt(cu_halt), .rs(cu_rs), .rt(cu_rt), .wsel(cu_wsel), .shamt(cu_shamt),
      .imm16(cu_imm16)
   );

   register_file rf_inst (
      .CLK(CLK), .rst(rst), .wen(mw_regwr), .wsel(mw_wsel), .wdat(mw_result),
      .rsel1(cu_rs), .rsel2(cu_rt), .rdat1(rdat1), .rdat2(rdat2)
   );

   hazard_unit hz_inst (
      .id_rs(cu_rs), .id_rt(cu_rt), .ex_rs(de_rs), .ex_rt(de_rt), .ex_load(de_ren),
      .ex_wsel(de_wsel), .mem_wsel(em_wsel), .mem_regwr(em_regwr), .wb_wsel(mw_wsel),
      .wb_regwr(mw_regwr), .fwd_op1(fwd_op1), .fwd_op2(fwd_op2), .load_stall(load_stall)
   );

   alu alu_inst (.op1(op1), .op2(op2), .shamt(de_shamt), .alu_op(de_alu_op), .res(alu_res));

   //////////////////////////////////////////////////////////////////////
   // handshakes and stall
   //////////////////////////////////////////////////////////////////////
   assign stop_fetch = halt_seen | cu_halt;   // nothing past halt is fetched
   assign mem_op     = em_ren | em_wen;
   assign advance    = run & (fetch_valid | stop_fetch) & (~mem_op | d_done);

   assign i_addr  = pc[9:2];
   assign d_addr  = em_alu[9:2];
   assign d_wen   = em_wen;
   assign d_wdata = em_store;

   always_ff @(posedge CLK) begin
      if (rst) begin
         pc          <= PC_INIT;
         i_req       <= 1'b0;
         fetch_valid <= 1'b0;
         halt_seen   <= 1'b0;
         d_req       <= 1'b0;
         d_done      <= 1'b0;
      end else begin
         if (i_req && i_ack) begin
            i_req       <= 1'b0;
            fetch_valid <= 1'b1;
            fetch_buf   <= i_rdata;
         end else if (run && !i_req && !i_ack && !fetch_valid && !stop_fetch) begin
            i_req <= 1'b1;
         end
         if (d_req && d_ack) begin
            d_req  <= 1'b0;
            d_done <= 1'b1;
            d_load <= d_rdata;
         end else if (mem_op && !d_req && !d_ack && !d_done) begin
            d_req <= 1'b1;   // one transaction per lw/sw in MEM
         end
         if (advance) begin
            d_done <= 1'b0;
         end
         if (advance && !load_stall) begin
            fetch_valid <= 1'b0;
            if (!stop_fetch) begin
               pc <= pc + 32'd4;
            end
            if (cu_halt) begin
               halt_seen <= 1'b1;
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // EX operand muxes
   //////////////////////////////////////////////////////////////////////
   assign imm_ext = cu_ext_sign ? {{16{cu_imm16[15]}}, cu_imm16} : {16'b0, cu_imm16};

   always_comb begin
      case (fwd_op1)
         cpu_pkg::FWD_MEM: op1 = em_alu;
         cpu_pkg::FWD_WB:  op1 = mw_result;
         default:          op1 = de_rdat1;
      endcase
      case (fwd_op2)
         cpu_pkg::FWD_MEM: op2_reg = em_alu;
         cpu_pkg::FWD_WB:  op2_reg = mw_result;
         default:          op2_reg = de_rdat2;
      endcase
      case (de_alu_src)
         cpu_pkg::SRC_IMM:   op2 = de_imm;
         cpu_pkg::SRC_UPPER: op2 = {de_imm[15:0], 16'b0};   // lui
         default:            op2 = op2_reg;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // pipeline latches that move only on advance
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge CLK) begin
      if (rst) begin
         fd_instr <= '0;
         de_regwr <= 1'b0;
         de_ren   <= 1'b0;
         de_wen   <= 1'b0;
         de_halt  <= 1'b0;
         em_regwr <= 1'b0;
         em_ren   <= 1'b0;
         em_wen   <= 1'b0;
         em_halt  <= 1'b0;
         mw_regwr <= 1'b0;
         halted   <= 1'b0;
      end else if (advance) begin
         if (!load_stall) begin
            fd_instr <= stop_fetch ? '0 : fetch_buf;   // nop once halt is in ID
         end
         de_rdat1    <= rdat1;
         de_rdat2    <= rdat2;
         de_imm      <= imm_ext;
         de_shamt    <= cu_shamt;
         de_alu_op   <= cu_alu_op;
         de_alu_src  <= cu_alu_src;
         de_rs       <= cu_rs;
         de_rt       <= cu_rt;
         de_wsel     <= cu_wsel;
         de_memtoreg <= cu_memtoreg;
         de_regwr    <= cu_regwr & ~load_stall;   // bubble on load-use
         de_ren      <= cu_ren & ~load_stall;
         de_wen      <= cu_wen & ~load_stall;
         de_halt     <= cu_halt & ~load_stall;
         em_alu      <= alu_res;
         em_store    <= op2_reg;
         em_wsel     <= de_wsel;
         em_regwr    <= de_regwr;
         em_memtoreg <= de_memtoreg;
         em_ren      <= de_ren;
         em_wen      <= de_wen;
         em_halt     <= de_halt;
         mw_result   <= em_memtoreg ? d_load : em_alu;
         mw_wsel     <= em_wsel;
         mw_regwr    <= em_regwr;
         if (em_halt) begin
            halted <= 1'b1;   // halt entering WB
         end
      end
   end

   // req and its request fields hold until the ack is seen
   assert property (@(posedge CLK) disable iff (rst)
      i_req && !i_ack |=> i_req && $stable(i_addr));
   assert property (@(posedge CLK) disable iff (rst)
      d_req && !d_ack |=> d_req && $stable(d_addr) && $stable(d_wen) && $stable(d_wdata));

endmodule

`default_nettype wire

// ==== memory_arbiter.sv ====
// fixed-priority arbiter, host over data over fetch, holding each four-phase exchange to the ram
`timescale 1ns/1ns
`default_nettype none

module memory_arbiter (
   input  logic               CLK,
   input  logic               rst,
   input  logic               host_req,
   input  logic               host_wen,
   input  cpu_pkg::mem_addr_t host_addr,
   input  cpu_pkg::word_t     host_wdata,
   output logic               host_ack,
   output cpu_pkg::word_t     host_rdata,
   input  logic               d_req,
   input  logic               d_wen,
   input  cpu_pkg::mem_addr_t d_addr,
   input  cpu_pkg::word_t     d_wdata,
   output logic               d_ack,
   output cpu_pkg::word_t     d_rdata,
   input  logic               i_req,
   input  cpu_pkg::mem_addr_t i_addr,
   output logic               i_ack,
   output cpu_pkg::word_t     i_rdata,
   output logic               m_req,
   output logic               m_wen,
   output cpu_pkg::mem_addr_t m_addr,
   output cpu_pkg::word_t     m_wdata,
   input  logic               m_ack,
   input  cpu_pkg::word_t     m_rdata
);

   typedef enum logic [1:0] {OWN_NONE, OWN_HOST, OWN_DATA, OWN_FETCH} owner_t;
   owner_t owner;

   always_ff @(posedge CLK) begin
      if (rst) begin
         owner <= OWN_NONE;
      end else if (owner == OWN_NONE) begin
         if (host_req)   owner <= OWN_HOST;
         else if (d_req) owner <= OWN_DATA;
         else if (i_req) owner <= OWN_FETCH;
      end else if (!m_req && !m_ack) begin
         owner <= OWN_NONE;   // whole req/ack cycle done
      end
   end

   always_comb begin
      m_req   = 1'b0;
      m_wen   = 1'b0;
      m_addr  = i_addr;
      m_wdata = d_wdata;
      case (owner)
         OWN_HOST: begin
            m_req   = host_req;
            m_wen   = host_wen;
            m_addr  = host_addr;
            m_wdata = host_wdata;
         end
         OWN_DATA: begin
            m_req  = d_req;
            m_wen  = d_wen;
            m_addr = d_addr;
         end
         OWN_FETCH: m_req = i_req;   // read only
         default:   m_req = 1'b0;
      endcase
   end

   assign host_ack   = (owner == OWN_HOST) & m_ack;
   assign d_ack      = (owner == OWN_DATA) & m_ack;
   assign i_ack      = (owner == OWN_FETCH) & m_ack;
   assign host_rdata = m_rdata;
   assign d_rdata    = m_rdata;
   assign i_rdata    = m_rdata;

   // grant cannot move while the memory request is up
   assert property (@(posedge CLK) disable iff (rst) m_req |=> owner == $past(owner));
   // every memory ack lands on the port that was requesting
   assert property (@(posedge CLK) disable iff (rst)
      m_ack |-> (host_ack && $past(host_req)) || (d_ack && $past(d_req)) ||
                (i_ack && $past(i_req)));

endmodule

`default_nettype wire

// ==== ram.sv ====
// single-port word memory behind the arbiter, acking each request after RAM_LATENCY cycles
`timescale 1ns/1ns
`default_nettype none

module ram #(
   parameter int RAM_LATENCY = 2
) (
   input  logic               CLK,
   input  logic               rst,
   input  logic               m_req,
   input  logic               m_wen,
   input  cpu_pkg::mem_addr_t m_addr,
   input  cpu_pkg::word_t     m_wdata,
   output logic               m_ack,
   output cpu_pkg::word_t     m_rdata
);

   localparam int CW = $clog2(RAM_LATENCY + 1);

   cpu_pkg::word_t mem [2**$bits(cpu_pkg::mem_addr_t)];
   logic [CW-1:0]  cnt;
   logic           done;

   assign done = m_req && !m_ack && (cnt == CW'(RAM_LATENCY));

   always_ff @(posedge CLK) begin
      if (rst) begin
         m_ack <= 1'b0;
         cnt   <= '0;
      end else if (m_ack) begin
         if (!m_req) m_ack <= 1'b0;   // fourth phase
      end else if (done) begin
         m_ack <= 1'b1;
         cnt   <= '0;
      end else if (m_req) begin
         cnt <= cnt + 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (done) begin
         if (m_wen) mem[m_addr] <= m_wdata;
         m_rdata <= m_wen ? m_wdata : mem[m_addr];
      end
   end

   // ack rises RAM_LATENCY cycles after the request is first seen
   assert property (@(posedge CLK) disable iff (rst)
      $rose(m_ack) |-> $past(m_req, RAM_LATENCY + 1));

endmodule

`default_nettype wire

// ==== cpu_system.sv ====
// top level joining core, arbiter and ram, with the host port brought out for load and readback
`timescale 1ns/1ns
`default_nettype none

module cpu_system #(
   parameter cpu_pkg::word_t PC_INIT     = 32'h0,
   parameter int             RAM_LATENCY = 2
) (
   input  logic               CLK,
   input  logic               rst,
   input  logic               run,
   input  logic               host_req,
   input  logic               host_wen,
   input  cpu_pkg::mem_addr_t host_addr,
   input  cpu_pkg::word_t     host_wdata,
   output logic               host_ack,
   output cpu_pkg::word_t     host_rdata,
   output logic               halted
);

   logic               i_req, i_ack, d_req, d_wen, d_ack, m_req, m_wen, m_ack;
   cpu_pkg::mem_addr_t i_addr, d_addr, m_addr;
   cpu_pkg::word_t     i_rdata, d_wdata, d_rdata, m_wdata, m_rdata;

   datapath #(.PC_INIT(PC_INIT)) datapath_inst (
      .CLK(CLK), .rst(rst), .run(run),
      .i_req(i_req), .i_addr(i_addr), .i_ack(i_ack), .i_rdata(i_rdata),
      .d_req(d_req), .d_wen(d_wen), .d_addr(d_addr), .d_wdata(d_wdata),
      .d_ack(d_ack), .d_rdata(d_rdata), .halted(halted)
   );

   memory_arbiter arbiter_inst (
      .CLK(CLK), .rst(rst),
      .host_req(host_req), .host_wen(host_wen), .host_addr(host_addr),
      .host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata),
      .d_req(d_req), .d_wen(d_wen), .d_addr(d_addr), .d_wdata(d_wdata),
      .d_ack(d_ack), .d_rdata(d_rdata),
      .i_req(i_req), .i_addr(i_addr), .i_ack(i_ack), .i_rdata(i_rdata),
      .m_req(m_req), .m_wen(m_wen), .m_addr(m_addr), .m_wdata(m_wdata),
      .m_ack(m_ack), .m_rdata(m_rdata)
   );

   ram #(.RAM_LATENCY(RAM_LATENCY)) ram_inst (
      .CLK(CLK), .rst(rst), .m_req(m_req), .m_wen(m_wen), .m_addr(m_addr),
      .m_wdata(m_wdata), .m_ack(m_ack), .m_rdata(m_rdata)
   );

endmodule

`default_nettype wire

// ==== tb_cpu_system.sv ====
// testbench for cpu_system: loads programs over the host port, runs them, checks data memory
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_system;

   localparam int MEM_WORDS       = 2**$bits(cpu_pkg::mem_addr_t);
   localparam int DATA_BASE       = 128;   // words below hold the program
   localparam int DATA_WORDS      = 32;
   localparam int NUM_RANDOM      = 6;
   localparam int NUM_PROGS       = 4 + NUM_RANDOM;
   localparam int PROG_LEN        = 64;    // longest program, epilogue included
   localparam int WATCHDOG_CYCLES = NUM_PROGS * PROG_LEN * 40;

   logic               CLK = 1'b0;
   logic               rst, run, host_req, host_wen, host_ack, halted;
   cpu_pkg::mem_addr_t host_addr;
   cpu_pkg::word_t     host_wdata, host_rdata;

   cpu_pkg::word_t     mem_ref [MEM_WORDS];   // ISA-level image of the shared memory
   cpu_pkg::word_t     prog [$];
   string              what_q [$];
   cpu_pkg::word_t     got_q [$];
   cpu_pkg::word_t     exp_q [$];
   logic [31:0]        rng_state = 32'h7def;
   int                 errors = 0;
   int                 checks = 0;

   cpu_system #(.PC_INIT(32'h0), .RAM_LATENCY(2)) cpu_system_inst (
      .CLK(CLK), .rst(rst), .run(run),
      .host_req(host_req), .host_wen(host_wen), .host_addr(host_addr),
      .host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata),
      .halted(halted)
   );

   always #50 CLK = ~CLK;

   function automatic logic [31:0] xorshift();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic cpu_pkg::word_t encode_r(input logic [5:0] funct, input int rd, rs, rt, sh);
      return {6'b0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
   endfunction

   function automatic cpu_pkg::word_t encode_i(input logic [5:0] op, input int rt, rs, imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // ISA reference, one instruction at a time over mem_ref
   //////////////////////////////////////////////////////////////////////
   function automatic void ref_run();
      cpu_pkg::word_t regs [32];
      cpu_pkg::word_t ins, a, b, sx, addr;
      logic [4:0]     rd, rt;
      int             pc;
      logic           stop;
      for (int r = 0; r < 32; r++) begin
         regs[r] = '0;
      end
      pc   = 0;
      stop = 1'b0;
      while (pc < DATA_BASE && !stop) begin
         ins  = mem_ref[pc];
         pc++;
         rd   = ins[15:11];
         rt   = ins[20:16];
         a    = regs[ins[25:21]];
         b    = regs[rt];
         sx   = {{16{ins[15]}}, ins[15:0]};
         addr = a + sx;
         case (ins[31:26])
            cpu_pkg::RTYPE: begin
               case (ins[5:0])
                  cpu_pkg::ADDU: regs[rd] = a + b;
                  cpu_pkg::SUBU: regs[rd] = a - b;
                  cpu_pkg::AND:  regs[rd] = a & b;
                  cpu_pkg::OR:   regs[rd] = a | b;
                  cpu_pkg::SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  cpu_pkg::SLL:  regs[rd] = b << ins[10:6];
                  default: ;
               endcase
            end
            cpu_pkg::ADDIU: regs[rt] = a + sx;
            cpu_pkg::ORI:   regs[rt] = a | {16'b0, ins[15:0]};   // zero extended
            cpu_pkg::LUI:   regs[rt] = {ins[15:0], 16'b0};
            cpu_pkg::LW:    regs[rt] = mem_ref[addr[9:2]];
            cpu_pkg::SW:    mem_ref[addr[9:2]] = b;
            cpu_pkg::HALT:  stop = 1'b1;
            default: ;
         endcase
         regs[0] = '0;
      end
   endfunction

   task automatic check(input string what, input cpu_pkg::word_t got, input cpu_pkg::word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Fail %0t ns: %s got %08h expected %08h", $time, what, got, exp);
      end
   endtask

   // four-phase exchange on the host port
   task automatic host_handshake(input logic wen, input int addr, input cpu_pkg::word_t wdata,
                                 output cpu_pkg::word_t rdata);
      @(posedge CLK);
      host_req   <= 1'b1;
      host_wen   <= wen;
      host_addr  <= cpu_pkg::mem_addr_t'(addr);
      host_wdata <= wdata;
      @(negedge CLK);
      while (host_ack !== 1'b1) @(negedge CLK);
      rdata = host_rdata;
      @(posedge CLK);
      host_req <= 1'b0;
      @(negedge CLK);
      while (host_ack !== 1'b0) @(negedge CLK);
   endtask

   task automatic host_write(input int addr, input cpu_pkg::word_t data);
      cpu_pkg::word_t unused;
      host_handshake(1'b1, addr, data, unused);
   endtask

   task automatic host_read(input int addr, output cpu_pkg::word_t data);
      host_handshake(1'b0, addr, '0, data);
   endtask

   task automatic apply_reset();
      @(posedge CLK);
      rst <= 1'b1;
      run <= 1'b0;
      repeat (10) @(posedge CLK);
      rst <= 1'b0;
      @(negedge CLK);
   endtask

   //////////////////////////////////////////////////////////////////////
   // programs
   //////////////////////////////////////////////////////////////////////
   function automatic void add_epilogue();
      for (int r = 0; r < 16; r++) begin
         prog.push_back(encode_i(cpu_pkg::SW, r, 0, 512 + 4 * r));   // $r to word 128+r
      end
      prog.push_back(encode_i(cpu_pkg::HALT, 0, 0, 0));
   endfunction

   function automatic void alu_program();
      prog.delete();
      prog.push_back(encode_i(cpu_pkg::ADDIU, 1, 0, 100));
      prog.push_back(encode_i(cpu_pkg::ADDIU, 2, 0, -7));
      prog.push_back(encode_r(cpu_pkg::ADDU, 3, 1, 2, 0));   // $2 from MEM, $1 from WB
      prog.push_back(encode_r(cpu_pkg::SUBU, 4, 2, 3, 0));
      prog.push_back(encode_r(cpu_pkg::AND, 5, 4, 1, 0));
      prog.push_back(encode_r(cpu_pkg::OR, 6, 5, 4, 0));
      prog.push_back(encode_r(cpu_pkg::SLT, 7, 4, 1, 0));
      prog.push_back(encode_r(cpu_pkg::ADDU, 8, 3, 3, 0));
      add_epilogue();
   endfunction

   function automatic void load_use_program();
      prog.delete();
      prog.push_back(encode_i(cpu_pkg::LW, 1, 0, 576));
      prog.push_back(encode_r(cpu_pkg::ADDU, 2, 1, 1, 0));   // direct use of the load
      prog.push_back(encode_i(cpu_pkg::LW, 3, 0, 580));
      prog.push_back(encode_i(cpu_pkg::SW, 3, 0, 600));      // store data from the load
      prog.push_back(encode_i(cpu_pkg::LW, 4, 0, 600));
      prog.push_back(encode_r(cpu_pkg::SUBU, 5, 4, 2, 0));
      prog.push_back(encode_i(cpu_pkg::LW, 6, 0, 584));
      prog.push_back(encode_i(cpu_pkg::LW, 7, 0, 588));
      prog.push_back(encode_r(cpu_pkg::OR, 8, 6, 7, 0));
      prog.push_back(encode_i(cpu_pkg::LW, 9, 0, 576));
      prog.push_back(encode_i(cpu_pkg::ADDIU, 9, 9, 1));
      add_epilogue();
   endfunction

   function automatic void constant_program();
      prog.delete();
      prog.push_back(encode_i(cpu_pkg::LUI, 1, 0, 16'h8000));
      prog.push_back(encode_i(cpu_pkg::ORI, 1, 1, 16'h1234));
      prog.push_back(encode_i(cpu_pkg::LUI, 2, 0, 16'h7fff));
      prog.push_back(encode_i(cpu_pkg::ORI, 2, 2, 16'hffff));
      prog.push_back(encode_r(cpu_pkg::SLL, 3, 0, 1, 4));
      prog.push_back(encode_r(cpu_pkg::SLT, 4, 1, 2, 0));    // negative below positive
      prog.push_back(encode_r(cpu_pkg::SLT, 5, 2, 1, 0));
      prog.push_back(encode_i(cpu_pkg::ADDIU, 6, 0, -1));
      prog.push_back(encode_r(cpu_pkg::SLT, 7, 6, 0, 0));
      prog.push_back(encode_r(cpu_pkg::SLL, 8, 0, 6, 31));
      add_epilogue();
   endfunction

   // writes to $0 must not stick, and words 144..159 are never stored
   function automatic void zero_reg_program();
      prog.delete();
      prog.push_back(encode_i(cpu_pkg::ADDIU, 0, 0, 55));
      prog.push_back(encode_i(cpu_pkg::ORI, 0, 0, 16'hffff));
      prog.push_back(encode_r(cpu_pkg::ADDU, 1, 0, 0, 0));
      add_epilogue();
   endfunction

   function automatic void random_program(input int count);
      logic [31:0] r;
      int          rd, rs, rt, mem_off;
      prog.delete();
      for (int n = 0; n < count; n++) begin
         r       = xorshift();
         rd      = r[3:0];
         rs      = r[7:4];
         rt      = r[11:8];
         mem_off = 512 + 4 * r[16:12];   // somewhere in the 32 data words
         case (r[31:28])
            4'd0:           prog.push_back(encode_r(cpu_pkg::ADDU, rd, rs, rt, 0));
            4'd1:           prog.push_back(encode_r(cpu_pkg::SUBU, rd, rs, rt, 0));
            4'd2:           prog.push_back(encode_r(cpu_pkg::AND, rd, rs, rt, 0));
            4'd3:           prog.push_back(encode_r(cpu_pkg::OR, rd, rs, rt, 0));
            4'd4:           prog.push_back(encode_r(cpu_pkg::SLT, rd, rs, rt, 0));
            4'd5:           prog.push_back(encode_r(cpu_pkg::SLL, rd, 0, rt, r[21:17]));
            4'd6, 4'd7:     prog.push_back(encode_i(cpu_pkg::ADDIU, rt, rs, r[27:12]));
            4'd8:           prog.push_back(encode_i(cpu_pkg::ORI, rt, rs, r[27:12]));
            4'd9:           prog.push_back(encode_i(cpu_pkg::LUI, rt, 0, r[27:12]));
            4'd10, 4'd11,
            4'd12:          prog.push_back(encode_i(cpu_pkg::LW, rt, 0, mem_off));
            4'd13, 4'd14:   prog.push_back(encode_i(cpu_pkg::SW, rt, 0, mem_off));
            default:        prog.push_back(encode_r(cpu_pkg::ADDU, rd, rt, rd, 0));
         endcase
      end
      add_epilogue();
   endfunction

   //////////////////////////////////////////////////////////////////////
   // load, run, read back
   //////////////////////////////////////////////////////////////////////
   task automatic run_program(input string name);
      cpu_pkg::word_t v;
      cpu_pkg::word_t got;
      apply_reset();
      check({name, " halted after reset"}, {31'b0, halted}, 32'h0);
      foreach (prog[i]) begin
         mem_ref[i] = prog[i];
         host_write(i, prog[i]);
      end
      for (int w = DATA_BASE; w < DATA_BASE + DATA_WORDS; w++) begin
         v          = xorshift();
         mem_ref[w] = v;
         host_write(w, v);
      end
      ref_run();
      @(posedge CLK);
      run <= 1'b1;
      while (halted !== 1'b1) @(negedge CLK);
      @(posedge CLK);
      run <= 1'b0;
      for (int w = DATA_BASE; w < DATA_BASE + DATA_WORDS; w++) begin
         host_read(w, got);
         what_q.push_back($sformatf("%s word %0d", name, w));
         got_q.push_back(got);
         exp_q.push_back(mem_ref[w]);
      end
   endtask

   // compare process, one readback per clock
   always @(posedge CLK) begin
      if (got_q.size() != 0) begin
         check(what_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
      end
   end

   initial begin
      rst        = 1'b1;
      run        = 1'b0;
      host_req   = 1'b0;
      host_wen   = 1'b0;
      host_addr  = '0;
      host_wdata = '0;
      alu_program();
      run_program("alu_fwd");
      load_use_program();
      run_program("load_use");
      constant_program();
      run_program("constants");
      zero_reg_program();
      run_program("zero_reg");
      for (int p = 0; p < NUM_RANDOM; p++) begin
         random_program(40);
         run_program($sformatf("random%0d", p));
      end
      while (got_q.size() != 0) @(posedge CLK);
      @(negedge CLK);
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // watchdog
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge CLK);
      $display("timeout: no halt or host ack within %0d cycles", WATCHDOG_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
cpu_pkg.sv
alu.sv
register_file.sv
control_unit.sv
hazard_unit.sv
datapath.sv
memory_arbiter.sv
ram.sv
cpu_system.sv
tb_cpu_system.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_system \
   -f verilog.f -o sim_cpu || { echo "build failed"; exit 1; }
./obj_dir/sim_cpu > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
